// ==== denise_top.f ====
hdl/denise_pkg.sv
hdl/denise_regs.sv
hdl/bitplane_shifter.sv
hdl/color_table.sv
hdl/display_window.sv
hdl/video_out.sv
hdl/denise_top.sv
verification/denise_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= denise_tb
FILELIST  ?= denise_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean

// ==== verification/denise_tb.sv ====
/*
  Random testbench for the playfield video path.
  A cycle model fed from the same bus words predicts db_out, db_oen,
  rgb and blank_n, compared on every falling clock edge. Tests cover
  ID reads, color writes, bitplane words, half brite and the window.
*/
`timescale 1ns/1ns

module denise_tb import denise_pkg::*; ();

  localparam int          NUM_PLANES     = 6;
  localparam int unsigned SEED           = 32'he4479adb;
  // Six lines of cycles plus slack for the setup writes
  localparam int          TIMEOUT_CYCLES = 6 * 600 + 400;

  logic              clk;
  logic              arst_n;
  logic [RGA_W-1:0]  rga;
  logic [DATA_W-1:0] db_in;
  logic [DATA_W-1:0] db_out;
  logic              db_oen;
  logic [COMP_W-1:0] red;
  logic [COMP_W-1:0] green;
  logic [COMP_W-1:0] blue;
  logic              blank_n;

  int               errors;
  int               checks;
  int               cycles;
  int               tests_ok;
  int               tests_bad;
  logic             colors_loaded;
  logic [RGB_W-1:0] color0;

  // Model state
  // d_* holds the bus word seen one edge earlier
  logic [RGA_W-1:0]  d_rga;
  logic [DATA_W-1:0] d_db;
  logic [RGB_W-1:0]  m_clut [CLUT_DEPTH];
  logic [DATA_W-1:0] m_hold [NUM_PLANES];
  logic [DATA_W-1:0] m_shift [NUM_PLANES];
  logic              m_load;
  logic [2:0]        m_bpu;
  logic [IDX_W-1:0]  m_pix;
  logic [HPOS_W-1:0] m_hpos;
  logic [HPOS_W-1:0] m_start;
  logic [HPOS_W-1:0] m_stop;
  logic              m_win;
  logic [RGB_W-1:0]  m_rd;
  logic [RGB_W-1:0]  m_rgb;
  logic              m_blank_n;
  logic [DATA_W-1:0] m_db_out;
  logic              m_db_oen;

  denise_top #(.NUM_PLANES(NUM_PLANES)) denise_top_i (
    .clk, .arst_n, .rga, .db_in, .db_out, .db_oen,
    .red, .green, .blue, .blank_n
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Color lookup with index bit 5 picking index minus 32 at half level
  function automatic logic [RGB_W-1:0] lookup_color(input logic [IDX_W-1:0] idx);
    logic [RGB_W-1:0] c;
    c = m_clut[idx[4:0]];
    if (idx[5])
      c = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model stepped on each rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_rga = ADDR_NOP;
      d_db = '0;
      m_load = 1'b0;
      m_bpu = '0;
      m_pix = '0;
      m_hpos = '0;
      m_start = 9'h000;
      m_stop = 9'h100;
      m_win = 1'b0;
      m_rd = '0;
      m_rgb = '0;
      m_blank_n = 1'b0;
      m_db_out = '0;
      m_db_oen = 1'b0;
      for (int p = 0; p < NUM_PLANES; p++) begin
        m_hold[p] = '0;
        m_shift[p] = '0;
      end
    end else begin
      // Output stage from values held one edge back
      m_blank_n = m_win;
      m_rgb = m_win ? m_rd : '0;
      m_rd = lookup_color(m_pix);
      // Window state from the old beam position
      if (m_hpos == m_start)
        m_win = 1'b1;
      else if (m_hpos == m_stop)
        m_win = 1'b0;
      m_hpos = (d_rga == ADDR_STRHOR) ? '0 : m_hpos + 9'd1;
      // Parallel load with masked planes, else shift left
      for (int p = 0; p < NUM_PLANES; p++)
        m_shift[p] = m_load ? ((3'(p) < m_bpu) ? m_hold[p] : '0) : {m_shift[p][14:0], 1'b0};
      m_load = (d_rga[7:3] == ADDR_BPL1DAT[7:3]) && (d_rga[2:0] == 3'd0);
      // Register writes land two edges after the word is presented
      m_db_oen = (d_rga == ADDR_DENISEID);
      if (m_db_oen)
        m_db_out = DENISE_ID;
      if (d_rga == ADDR_BPLCON0)
        m_bpu = (d_db[14:12] > 3'(NUM_PLANES)) ? 3'(NUM_PLANES) : d_db[14:12];
      if (d_rga == ADDR_DIWSTRT)
        m_start = {1'b0, d_db[7:0]};
      if (d_rga == ADDR_DIWSTOP)
        m_stop = {1'b1, d_db[7:0]};
      if (d_rga[7:3] == ADDR_BPL1DAT[7:3])
        m_hold[d_rga[2:0]] = d_db;
      if (d_rga[7:5] == ADDR_COLOR00[7:5])
        m_clut[d_rga[4:0]] = d_db[11:0];
      m_pix = '0;
      for (int p = 0; p < NUM_PLANES; p++)
        m_pix[p] = m_shift[p][DATA_W-1];
      d_rga = rga;
      d_db = db_in;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      check_val("db_oen", 16'(db_oen), 16'(m_db_oen));
      check_val("db_out", db_out, m_db_out);
      check_val("blank_n", 16'(blank_n), 16'(m_blank_n));
      if (colors_loaded)
        check_val("rgb", 16'({red, green, blue}), 16'(m_rgb));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus stimulus and tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic [RGA_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge clk);
    #2;
    rga = addr;
    db_in = data;
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic read_chip_id();
    int err_start;
    err_start = errors;
    for (int i = 0; i < 4; i++) begin
      bus_cycle(ADDR_DENISEID, 16'($urandom));
      bus_cycle(ADDR_NOP, 16'h0000);
      // Read data shows after the second edge, for one cycle
      @(posedge clk);
      @(negedge clk);
      check_val("db_oen", 16'(db_oen), 16'h0001);
      check_val("db_out", db_out, DENISE_ID);
      @(negedge clk);
      check_val("db_oen", 16'(db_oen), 16'h0000);
      repeat (1 + int'($urandom % 4)) bus_cycle(ADDR_NOP, 16'h0000);
    end
    report_test("id read", err_start);
  endtask

  task automatic fill_color_table();
    int               err_start;
    logic [DATA_W-1:0] word;
    err_start = errors;
    // No planes, wide window
    bus_cycle(ADDR_BPLCON0, 16'($urandom) & 16'h8FFF);
    bus_cycle(ADDR_DIWSTRT, {8'($urandom), 4'h0, 4'($urandom)});
    bus_cycle(ADDR_DIWSTOP, {8'($urandom), 4'hF, 4'($urandom)});
    for (int i = 0; i < CLUT_DEPTH; i++) begin
      word = 16'($urandom);
      if (i == 0)
        color0 = word[11:0];
      bus_cycle(ADDR_COLOR00 | 8'(i), word);
    end
    bus_cycle(ADDR_STRHOR, 16'($urandom));
    repeat (4) bus_cycle(ADDR_NOP, 16'h0000);
    colors_loaded = 1'b1;
    repeat (600) begin
      bus_cycle(ADDR_NOP, 16'h0000);
      @(negedge clk);
      if (blank_n)
        check_val("rgb", 16'({red, green, blue}), 16'(color0));
    end
    report_test("color table", err_start);
  endtask

  // Plane counts 1 to 5, or 6 and above for half brite
  task automatic shift_planes(input string name, input logic ehb);
    int         err_start;
    logic [2:0] count;
    err_start = errors;
    for (int it = 0; it < 8; it++) begin
      count = ehb ? 3'(6 + $urandom % 2) : 3'(1 + $urandom % 5);
      bus_cycle(ADDR_STRHOR, 16'h0000);
      bus_cycle(ADDR_BPLCON0, {1'($urandom), count, 12'($urandom)});
      repeat (24) bus_cycle(ADDR_NOP, 16'h0000);
      // All planes written with BPL1DAT last to start the word
      for (int p = NUM_PLANES - 1; p >= 0; p--)
        bus_cycle(ADDR_BPL1DAT + 8'(p), 16'($urandom));
      repeat (24) bus_cycle(ADDR_NOP, 16'h0000);
      @(negedge clk);
      if (blank_n)
        check_val("rgb", 16'({red, green, blue}), 16'(color0));
    end
    report_test(name, err_start);
  endtask

  task automatic sweep_window();
    int err_start;
    err_start = errors;
    for (int it = 0; it < 3; it++) begin
      bus_cycle(ADDR_STRHOR, 16'($urandom));
      bus_cycle(ADDR_DIWSTRT, 16'($urandom));
      bus_cycle(ADDR_DIWSTOP, 16'($urandom));
      repeat (520) begin
        bus_cycle(ADDR_NOP, 16'h0000);
        @(negedge clk);
        if (!blank_n)
          check_val("rgb", 16'({red, green, blue}), 16'h0000);
      end
    end
    report_test("display window", err_start);
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    rga = ADDR_NOP;
    db_in = '0;
    errors = 0;
    checks = 0;
    cycles = 0;
    tests_ok = 0;
    tests_bad = 0;
    colors_loaded = 1'b0;
    color0 = '0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;
    read_chip_id();
    fill_color_table();
    shift_planes("plane counts", 1'b0);
    shift_planes("half brite", 1'b1);
    sweep_window();
    $display("tests ok %0d, tests with errors %0d, checks %0d, errors %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== hdl/denise_top.sv ====
/*
  Playfield video path top level.
  Register front end feeds the bitplane shifters, the color table and
  the window logic; the final stage registers the blanked RGB output.
  Pixels appear four clocks after the BPL1DAT write is latched.
*/
`timescale 1ns/1ns

module denise_top import denise_pkg::*; #(
  parameter int NUM_PLANES = 6
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [RGA_W-1:0]  rga,
  input  logic [DATA_W-1:0] db_in,
  output logic [DATA_W-1:0] db_out,
  output logic              db_oen,
  output logic [COMP_W-1:0] red,
  output logic [COMP_W-1:0] green,
  output logic [COMP_W-1:0] blue,
  output logic              blank_n
);

  // Bus front end to the datapath
  logic              bpl_wr;
  logic [2:0]        bpl_sel;
  logic [DATA_W-1:0] bpl_data;
  logic [2:0]        bpu;
  logic              clut_wr;
  logic [4:0]        clut_addr;
  reg_word_u         clut_data;
  logic              hsync_clr;
  logic [HPOS_W-1:0] diw_start;
  logic [HPOS_W-1:0] diw_stop;

  // Pixel pipeline
  logic [IDX_W-1:0]  pix_idx;
  logic [RGB_W-1:0]  clut_rgb;
  logic              win_ena;

  denise_regs #(.NUM_PLANES(NUM_PLANES)) denise_regs_i (
    .clk, .arst_n, .rga, .db_in, .db_out, .db_oen,
    .bpl_wr, .bpl_sel, .bpl_data, .bpu,
    .clut_wr, .clut_addr, .clut_data,
    .hsync_clr, .diw_start, .diw_stop
  );

  bitplane_shifter #(.NUM_PLANES(NUM_PLANES)) bitplane_shifter_i (
    .clk, .arst_n, .bpl_wr, .bpl_sel, .bpl_data, .bpu, .pix_idx
  );

  // Low five index bits address the table
  color_table color_table_i (
    .clk, .arst_n, .clut_wr, .clut_addr, .clut_data,
    .rd_idx   (pix_idx[4:0]),
    .clut_rgb
  );

  display_window display_window_i (
    .clk, .arst_n, .hsync_clr, .diw_start, .diw_stop, .win_ena
  );

  // Plane 6 bit selects half brite, delayed inside
  video_out video_out_i (
    .clk, .arst_n, .clut_rgb,
    .ehb_sel (pix_idx[5]),
    .win_ena, .red, .green, .blue, .blank_n
  );

endmodule

// ==== hdl/video_out.sv ====
/*
  Final pixel stage.
  Delays index bit 5 to meet the color read, halves each component for
  extra-half-brite, and blanks outside the window. One output register
  feeds red, green, blue and blank_n.
*/
`timescale 1ns/1ns

module video_out import denise_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [RGB_W-1:0]  clut_rgb,
  input  logic              ehb_sel,
  input  logic              win_ena,
  output logic [COMP_W-1:0] red,
  output logic [COMP_W-1:0] green,
  output logic [COMP_W-1:0] blue,
  output logic              blank_n
);

  logic             ehb_q;
  logic [RGB_W-1:0] ehb_rgb;
  logic [RGB_W-1:0] rgb_q;

  // Half brightness, each component shifted right on its own
  assign ehb_rgb = {1'b0, clut_rgb[11:9], 1'b0, clut_rgb[7:5], 1'b0, clut_rgb[3:1]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ehb_q   <= 1'b0;
      rgb_q   <= '0;
      blank_n <= 1'b0;
    end else begin
      // Bit 5 lines up with the CLUT data
      ehb_q   <= ehb_sel;
      blank_n <= win_ena;
      if (!win_ena)
        rgb_q <= '0;
      else if (ehb_q)
        rgb_q <= ehb_rgb;
      else
        rgb_q <= clut_rgb;
    end
  end

  assign red   = rgb_q[11:8];
  assign green = rgb_q[7:4];
  assign blue  = rgb_q[3:0];

endmodule

// ==== hdl/display_window.sv ====
/*
  Horizontal beam counter and display window state.
  hpos counts every clock and wraps at 512; the STRHOR strobe clears it.
  win_ena opens when hpos hits diw_start and closes on diw_stop,
  one clock after the matching hpos value.
*/
`timescale 1ns/1ns

module display_window import denise_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              hsync_clr,
  input  logic [HPOS_W-1:0] diw_start,
  input  logic [HPOS_W-1:0] diw_stop,
  output logic              win_ena
);

  logic [HPOS_W-1:0] hpos_q;

  ////////////////////////////////////////////////////////////////////////////
  // Beam counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hpos_q <= '0;
    end else if (hsync_clr) begin
      hpos_q <= '0;
    end else begin
      // Natural wrap at 512
      hpos_q <= hpos_q + HPOS_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Window state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      win_ena <= 1'b0;
    end else if (hpos_q == diw_start) begin
      // Start wins if both match
      win_ena <= 1'b1;
    end else if (hpos_q == diw_stop) begin
      win_ena <= 1'b0;
    end
  end

endmodule

// ==== hdl/color_table.sv ====
/*
  Color look-up table, 32 entries of 12-bit RGB.
  The bus side stores the color view of the written word. The pixel
  side reads one entry per clock, returned a cycle later on clut_rgb.
*/
`timescale 1ns/1ns

module color_table import denise_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             clut_wr,
  input  logic [4:0]       clut_addr,
  input  reg_word_u        clut_data,
  input  logic [4:0]       rd_idx,
  output logic [RGB_W-1:0] clut_rgb
);

  logic [RGB_W-1:0] mem [CLUT_DEPTH];

  // Write port from the bus
  always_ff @(posedge clk) begin
    if (clut_wr)
      mem[clut_addr] <= {clut_data.color.red, clut_data.color.green, clut_data.color.blue};
  end

  // Registered read port, one pixel per clock
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clut_rgb <= '0;
    end else begin
      clut_rgb <= mem[rd_idx];
    end
  end

  // Index comes from the shifters, which are cleared by reset
  a_idx_known : assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(rd_idx));

endmodule

// ==== hdl/bitplane_shifter.sv ====
/*
  Bitplane holding registers and pixel shifters.
  BPLxDAT writes fill the holding registers. A BPL1DAT write arms a
  parallel load on the next edge, with planes at or above bpu cleared.
  Shifters then move left one pixel per clock; pix_idx is their top bits.
*/
`timescale 1ns/1ns

module bitplane_shifter import denise_pkg::*; #(
  parameter int NUM_PLANES = 6
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              bpl_wr,
  input  logic [2:0]        bpl_sel,
  input  logic [DATA_W-1:0] bpl_data,
  input  logic [2:0]        bpu,
  output logic [IDX_W-1:0]  pix_idx
);

  logic [DATA_W-1:0] hold_q  [NUM_PLANES];
  logic [DATA_W-1:0] shift_q [NUM_PLANES];
  logic              load_q;

  // Holding registers, payload only
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PLANES; p++) begin
      if (bpl_wr && (bpl_sel == 3'(p)))
        hold_q[p] <= bpl_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load pulse and shifters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_q <= 1'b0;
      for (int p = 0; p < NUM_PLANES; p++)
        shift_q[p] <= '0;
    end else begin
      // BPL1DAT is the last plane written, so it triggers the load
      load_q <= bpl_wr && (bpl_sel == 3'd0);
      for (int p = 0; p < NUM_PLANES; p++) begin
        if (load_q)
          shift_q[p] <= (3'(p) < bpu) ? hold_q[p] : '0;
        else
          shift_q[p] <= {shift_q[p][DATA_W-2:0], 1'b0};
      end
    end
  end

  // Bit p of the index is plane p; unbuilt planes read as zero
  always_comb begin
    pix_idx = '0;
    for (int p = 0; p < NUM_PLANES; p++)
      pix_idx[p] = shift_q[p][DATA_W-1];
  end

  // Register side clamps the plane count
  a_bpu_range : assert property (@(posedge clk) disable iff (!arst_n)
    bpu <= 3'(NUM_PLANES));

endmodule

// ==== hdl/denise_regs.sv ====
/*
  Register bus front end.
  Latches rga and db_in on every edge and decodes the latched address.
  Write strobes go out as one-cycle pulses along with the latched word;
  BPLCON0 plane count and the horizontal window are held here.
  A DENISEID read drives db_out with db_oen high for one cycle.
*/
`timescale 1ns/1ns

module denise_regs import denise_pkg::*; #(
  parameter int NUM_PLANES = 6
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [RGA_W-1:0]    rga,
  input  logic [DATA_W-1:0]   db_in,
  output logic [DATA_W-1:0]   db_out,
  output logic                db_oen,
  output logic                bpl_wr,
  output logic [2:0]          bpl_sel,
  output logic [DATA_W-1:0]   bpl_data,
  output logic [2:0]          bpu,
  output logic                clut_wr,
  output logic [4:0]          clut_addr,
  output reg_word_u           clut_data,
  output logic                hsync_clr,
  output logic [HPOS_W-1:0]   diw_start,
  output logic [HPOS_W-1:0]   diw_stop
);

  logic [RGA_W-1:0] rga_q;
  reg_word_u        db_q;
  logic             rd_id;
  logic             wr_bplcon0;
  logic             wr_diwstrt;
  logic             wr_diwstop;
  logic [7:0]       diw_start_q;
  logic [7:0]       diw_stop_q;

  ////////////////////////////////////////////////////////////////////////////
  // Bus latch and decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rga_q <= '0;
    end else begin
      rga_q <= rga;
    end
  end

  // Data word, no reset
  always_ff @(posedge clk) begin
    db_q.raw <= db_in;
  end

  // Strobes from the latched address
  assign hsync_clr  = (rga_q == ADDR_STRHOR);
  assign rd_id      = (rga_q == ADDR_DENISEID);
  assign wr_diwstrt = (rga_q == ADDR_DIWSTRT);
  assign wr_diwstop = (rga_q == ADDR_DIWSTOP);
  assign wr_bplcon0 = (rga_q == ADDR_BPLCON0);
  assign bpl_wr     = (rga_q[7:3] == ADDR_BPL1DAT[7:3]);
  assign clut_wr    = (rga_q[7:5] == ADDR_COLOR00[7:5]);

  // Register select and payload
  assign bpl_sel   = rga_q[2:0];
  assign bpl_data  = db_q.raw;
  assign clut_addr = rga_q[4:0];
  assign clut_data = db_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control registers and ID read
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bpu         <= '0;
      diw_start_q <= '0;
      diw_stop_q  <= '0;
      db_out      <= '0;
      db_oen      <= 1'b0;
    end else begin
      // Plane count limited to the planes built
      if (wr_bplcon0) begin
        if (db_q.bplcon0.bpu > 3'(NUM_PLANES))
          bpu <= 3'(NUM_PLANES);
        else
          bpu <= db_q.bplcon0.bpu;
      end
      if (wr_diwstrt)
        diw_start_q <= db_q.raw[7:0];
      if (wr_diwstop)
        diw_stop_q <= db_q.raw[7:0];
      // db_out keeps its last value between reads
      if (rd_id)
        db_out <= DENISE_ID;
      db_oen <= rd_id;
    end
  end

  // Start sits in the left half of the line, stop in the right half
  assign diw_start = {1'b0, diw_start_q};
  assign diw_stop  = {1'b1, diw_stop_q};

  // Bus never holds the read address two cycles running
  a_oen_single : assert property (@(posedge clk) disable iff (!arst_n)
    db_oen |=> !db_oen);

endmodule

// ==== hdl/denise_pkg.sv ====
/*
  Shared definitions for the playfield video path.
  Register addresses are rga[8:1] values, so each one is the byte
  address shifted right by one. Modules take this package by a
  wildcard import in their header.
*/
package denise_pkg;

  // Bus and datapath widths
  localparam int RGA_W      = 8;
  localparam int DATA_W     = 16;
  localparam int RGB_W      = 12;
  localparam int COMP_W     = RGB_W / 3;
  localparam int CLUT_DEPTH = 32;
  localparam int IDX_W      = 6;
  localparam int HPOS_W     = 9;

  ////////////////////////////////////////////////////////////////////////////
  // Register map, as rga[8:1]
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [RGA_W-1:0] ADDR_STRHOR   = 8'h1E;  // $03C
  localparam logic [RGA_W-1:0] ADDR_DENISEID = 8'h3E;  // $07C
  localparam logic [RGA_W-1:0] ADDR_DIWSTRT  = 8'h47;  // $08E
  localparam logic [RGA_W-1:0] ADDR_DIWSTOP  = 8'h48;  // $090
  localparam logic [RGA_W-1:0] ADDR_BPLCON0  = 8'h80;  // $100
  // BPLxDAT block, decoded on rga[8:4]
  localparam logic [RGA_W-1:0] ADDR_BPL1DAT  = 8'h88;  // $110
  // Color block, decoded on rga[8:6]
  localparam logic [RGA_W-1:0] ADDR_COLOR00  = 8'hC0;  // $180
  // Idle bus
  localparam logic [RGA_W-1:0] ADDR_NOP      = 8'hFF;  // $1FE

  // Chip-ID read value
  localparam logic [DATA_W-1:0] DENISE_ID = 16'hFFFC;

  ////////////////////////////////////////////////////////////////////////////
  // Data word views
  ////////////////////////////////////////////////////////////////////////////

  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [3:0]        unused;
      logic [COMP_W-1:0] red;
      logic [COMP_W-1:0] green;
      logic [COMP_W-1:0] blue;
    } color;
    struct packed {
      logic       hires;
      logic [2:0] bpu;
      logic       homod;
      logic       dblpf;
      logic [9:0] unused;
    } bplcon0;
  } reg_word_u;

endpackage
